//--- source/acc_pipe_config.svh
`ifndef ACC_PIPE_CONFIG_SVH
`define ACC_PIPE_CONFIG_SVH

// accumulator and data path width
`define ACC_DATA_W 16

// data memory words, 8-bit address in the instruction
`define ACC_DMEM_DEPTH 256

// host credits after reset, also ingress buffer depth
`define ACC_INS_CREDITS 4

// sink credits held by the result stage after reset
`define ACC_RES_CREDITS 4

// result queue slots
`define ACC_RESQ_DEPTH 8

`endif

//--- source/acc_pipe_pkg.sv
`default_nettype none

package acc_pipe_pkg;

    // instruction class, top nibble of every word
    typedef enum logic [3:0] {
        KIND_LDI  = 4'h0,
        KIND_ADDI = 4'h1,
        KIND_LD   = 4'h2,
        KIND_ST   = 4'h3,
        KIND_OPM  = 4'h4
    } instr_kind_e;

    // alu operations, same order as the original sixteen codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_MUL  = 4'h2,
        ALU_DIV  = 4'h3,
        ALU_SHL  = 4'h4,
        ALU_SHR  = 4'h5,
        ALU_ROL  = 4'h6,
        ALU_ROR  = 4'h7,
        ALU_AND  = 4'h8,
        ALU_OR   = 4'h9,
        ALU_XOR  = 4'ha,
        ALU_NOR  = 4'hb,
        ALU_NAND = 4'hc,
        ALU_XNOR = 4'hd,
        ALU_GT   = 4'he,
        ALU_EQ   = 4'hf
    } alu_op_e;

    // memory form: kind, op, address
    typedef struct packed {
        instr_kind_e kind;
        alu_op_e     op;
        logic [7:0]  addr;
    } instr_mem_t;

    // immediate form: kind, 12-bit immediate
    typedef struct packed {
        instr_kind_e kind;
        logic [11:0] imm;
    } instr_imm_t;

    // one 16-bit word, read in whichever form the kind needs
    typedef union packed {
        instr_mem_t mem;
        instr_imm_t imm;
    } instr_t;

endpackage

`default_nettype wire

//--- source/instr_buffer.sv
`timescale 1ns/1ns
`default_nettype none
`include "acc_pipe_config.svh"

module instr_buffer (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   instr_valid,
    input  acc_pipe_pkg::instr_t  instr,
    input  wire                   slot_free,
    output logic                  instr_credit,
    output logic                  launch_valid,
    output acc_pipe_pkg::instr_t  launch_instr
);

    localparam int DEPTH = `ACC_INS_CREDITS;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    // circular storage, one entry per host credit
    acc_pipe_pkg::instr_t fifo [DEPTH];
    logic [PW-1:0]        wr_ptr;
    logic [PW-1:0]        rd_ptr;
    logic [CW-1:0]        count;

    // head goes out only with a result slot reserved behind it
    assign launch_valid = (count != '0) && slot_free;
    assign launch_instr = fifo[rd_ptr];

    // host never sends without a credit, so no overflow check
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            fifo[wr_ptr] <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            instr_credit <= 1'b0;
        end else begin
            if (instr_valid) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (launch_valid) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy, push and pop may coincide
            count <= count + CW'(instr_valid) - CW'(launch_valid);
            // freed entry becomes a host credit next cycle
            instr_credit <= launch_valid;
        end
    end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "acc_pipe_config.svh"

module decode_stage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          launch_valid,
    input  acc_pipe_pkg::instr_t         launch_instr,
    output logic                         dec_valid,
    output acc_pipe_pkg::instr_kind_e    dec_kind,
    output acc_pipe_pkg::alu_op_e        dec_op,
    output logic [7:0]                   dec_addr,
    output logic [`ACC_DATA_W-1:0]       dec_imm,
    output logic                         dec_mem_read,
    output logic                         dec_illegal
);

    // stage register, raw word kept as is
    acc_pipe_pkg::instr_t ins_q;

    always_ff @(posedge clk) begin
        ins_q <= launch_instr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= launch_valid;
        end
    end

    // kind field sits in the same bits in both forms
    always_comb begin
        dec_kind     = ins_q.mem.kind;
        dec_op       = acc_pipe_pkg::ALU_ADD;
        dec_addr     = '0;
        dec_imm      = '0;
        dec_mem_read = 1'b0;
        dec_illegal  = 1'b0;
        case (ins_q.mem.kind)
            acc_pipe_pkg::KIND_LDI, acc_pipe_pkg::KIND_ADDI: begin
                // immediate form, zero extended
                dec_imm = `ACC_DATA_W'(ins_q.imm.imm);
            end
            acc_pipe_pkg::KIND_LD, acc_pipe_pkg::KIND_OPM: begin
                dec_op       = ins_q.mem.op;
                dec_addr     = ins_q.mem.addr;
                dec_mem_read = dec_valid;
            end
            acc_pipe_pkg::KIND_ST: begin
                dec_addr = ins_q.mem.addr;
            end
            default: begin
                dec_illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/operand_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "acc_pipe_config.svh"

module operand_stage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          dec_valid,
    input  acc_pipe_pkg::instr_kind_e    dec_kind,
    input  acc_pipe_pkg::alu_op_e        dec_op,
    input  wire [7:0]                    dec_addr,
    input  wire [`ACC_DATA_W-1:0]        dec_imm,
    input  wire                          dec_mem_read,
    input  wire                          dec_illegal,
    input  wire                          st_en,
    input  wire [7:0]                    st_addr,
    input  wire [`ACC_DATA_W-1:0]        st_data,
    output logic                         opd_valid,
    output acc_pipe_pkg::instr_kind_e    opd_kind,
    output acc_pipe_pkg::alu_op_e        opd_op,
    output logic [7:0]                   opd_addr,
    output logic [`ACC_DATA_W-1:0]       opd_imm,
    output logic [`ACC_DATA_W-1:0]       opd_mem_data,
    output logic                         opd_illegal
);

    localparam int DEPTH = `ACC_DMEM_DEPTH;

    // data memory, contents undefined until stored
    logic [`ACC_DATA_W-1:0] dmem [DEPTH];

    // store from execute, written at the end of its cycle
    always_ff @(posedge clk) begin
        if (st_en) begin
            dmem[st_addr] <= st_data;
        end
    end

    // synchronous read
    // store to the same address this cycle wins over the old word
    always_ff @(posedge clk) begin
        if (dec_mem_read) begin
            if (st_en && (st_addr == dec_addr)) begin
                opd_mem_data <= st_data;
            end else begin
                opd_mem_data <= dmem[dec_addr];
            end
        end
    end

    // control fields move along with the read
    always_ff @(posedge clk) begin
        opd_kind    <= dec_kind;
        opd_op      <= dec_op;
        opd_addr    <= dec_addr;
        opd_imm     <= dec_imm;
        opd_illegal <= dec_illegal;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            opd_valid <= 1'b0;
        end else begin
            opd_valid <= dec_valid;
        end
    end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "acc_pipe_config.svh"

module execute_stage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          opd_valid,
    input  acc_pipe_pkg::instr_kind_e    opd_kind,
    input  acc_pipe_pkg::alu_op_e        opd_op,
    input  wire [7:0]                    opd_addr,
    input  wire [`ACC_DATA_W-1:0]        opd_imm,
    input  wire [`ACC_DATA_W-1:0]        opd_mem_data,
    input  wire                          opd_illegal,
    output logic                         st_en,
    output logic [7:0]                   st_addr,
    output logic [`ACC_DATA_W-1:0]       st_data,
    output logic                         exe_valid,
    output logic [`ACC_DATA_W-1:0]       exe_acc,
    output logic                         exe_err
);

    localparam int W = `ACC_DATA_W;

    logic [W-1:0] acc_q;
    logic [W-1:0] alu_res;
    logic [W-1:0] acc_next;

    // alu, accumulator is always the left operand
    always_comb begin
        case (opd_op)
            acc_pipe_pkg::ALU_ADD:  alu_res = acc_q + opd_mem_data;
            acc_pipe_pkg::ALU_SUB:  alu_res = acc_q - opd_mem_data;
            // low half of the product only
            acc_pipe_pkg::ALU_MUL:  alu_res = acc_q * opd_mem_data;
            acc_pipe_pkg::ALU_DIV: begin
                // divide by zero gives all ones
                if (opd_mem_data == '0) begin
                    alu_res = '1;
                end else begin
                    alu_res = acc_q / opd_mem_data;
                end
            end
            acc_pipe_pkg::ALU_SHL:  alu_res = acc_q << 1;
            acc_pipe_pkg::ALU_SHR:  alu_res = acc_q >> 1;
            acc_pipe_pkg::ALU_ROL:  alu_res = {acc_q[W-2:0], acc_q[W-1]};
            acc_pipe_pkg::ALU_ROR:  alu_res = {acc_q[0], acc_q[W-1:1]};
            acc_pipe_pkg::ALU_AND:  alu_res = acc_q & opd_mem_data;
            acc_pipe_pkg::ALU_OR:   alu_res = acc_q | opd_mem_data;
            acc_pipe_pkg::ALU_XOR:  alu_res = acc_q ^ opd_mem_data;
            acc_pipe_pkg::ALU_NOR:  alu_res = ~(acc_q | opd_mem_data);
            acc_pipe_pkg::ALU_NAND: alu_res = ~(acc_q & opd_mem_data);
            acc_pipe_pkg::ALU_XNOR: alu_res = ~(acc_q ^ opd_mem_data);
            // compares give 1 or 0
            acc_pipe_pkg::ALU_GT:   alu_res = W'(acc_q > opd_mem_data);
            acc_pipe_pkg::ALU_EQ:   alu_res = W'(acc_q == opd_mem_data);
            default:                alu_res = '0;
        endcase
    end

    // next accumulator per instruction kind
    always_comb begin
        case (opd_kind)
            acc_pipe_pkg::KIND_LDI:  acc_next = opd_imm;
            acc_pipe_pkg::KIND_ADDI: acc_next = acc_q + opd_imm;
            acc_pipe_pkg::KIND_LD:   acc_next = opd_mem_data;
            acc_pipe_pkg::KIND_OPM:  acc_next = alu_res;
            // ST and illegal kinds keep the value
            default:                 acc_next = acc_q;
        endcase
    end

    // store port straight from the current accumulator
    assign st_en   = opd_valid && (opd_kind == acc_pipe_pkg::KIND_ST) && !opd_illegal;
    assign st_addr = opd_addr;
    assign st_data = acc_q;

    // accumulator doubles as the result word
    assign exe_acc = acc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q     <= '0;
            exe_valid <= 1'b0;
            exe_err   <= 1'b0;
        end else begin
            exe_valid <= opd_valid;
            if (opd_valid) begin
                exe_err <= opd_illegal;
                if (!opd_illegal) begin
                    acc_q <= acc_next;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/result_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "acc_pipe_config.svh"

module result_stage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     launch_valid,
    input  wire                     exe_valid,
    input  wire [`ACC_DATA_W-1:0]   exe_acc,
    input  wire                     exe_err,
    input  wire                     res_credit,
    output logic                    slot_free,
    output logic                    res_valid,
    output logic [`ACC_DATA_W-1:0]  res_data,
    output logic                    res_err
);

    localparam int DEPTH = `ACC_RESQ_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int QW    = $clog2(DEPTH + 1);
    localparam int CW    = $clog2(`ACC_RES_CREDITS + 1);

    logic [`ACC_DATA_W-1:0] q_data [DEPTH];
    logic                   q_err  [DEPTH];
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          rd_ptr;
    // entries actually written
    logic [QW-1:0]          occ_cnt;
    // written plus reserved by launches still in flight
    logic [QW-1:0]          rsv_cnt;
    logic [CW-1:0]          credit_cnt;
    logic                   pop;

    // room for one more launch
    assign slot_free = rsv_cnt < QW'(DEPTH);

    // one result per cycle, only with a sink credit
    assign pop = (occ_cnt != '0) && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (exe_valid) begin
            q_data[wr_ptr] <= exe_acc;
            q_err[wr_ptr]  <= exe_err;
        end
        if (pop) begin
            res_data <= q_data[rd_ptr];
            res_err  <= q_err[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            occ_cnt    <= '0;
            rsv_cnt    <= '0;
            credit_cnt <= CW'(`ACC_RES_CREDITS);
            res_valid  <= 1'b0;
        end else begin
            if (exe_valid) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            occ_cnt <= occ_cnt + QW'(exe_valid) - QW'(pop);
            // slot held from launch until the result leaves
            rsv_cnt <= rsv_cnt + QW'(launch_valid) - QW'(pop);
            // sink returns at most one credit per cycle
            credit_cnt <= credit_cnt + CW'(res_credit) - CW'(pop);
            res_valid  <= pop;
        end
    end

endmodule

`default_nettype wire

//--- source/acc_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "acc_pipe_config.svh"

module acc_pipe_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     instr_valid,
    input  acc_pipe_pkg::instr_t    instr,
    input  wire                     res_credit,
    output logic                    instr_credit,
    output logic                    res_valid,
    output logic [`ACC_DATA_W-1:0]  res_data,
    output logic                    res_err
);

    // ingress to decode
    logic                         slot_free;
    logic                         launch_valid;
    acc_pipe_pkg::instr_t         launch_instr;

    // decode to operand
    logic                         dec_valid;
    acc_pipe_pkg::instr_kind_e    dec_kind;
    acc_pipe_pkg::alu_op_e        dec_op;
    logic [7:0]                   dec_addr;
    logic [`ACC_DATA_W-1:0]       dec_imm;
    logic                         dec_mem_read;
    logic                         dec_illegal;

    // operand to execute
    logic                         opd_valid;
    acc_pipe_pkg::instr_kind_e    opd_kind;
    acc_pipe_pkg::alu_op_e        opd_op;
    logic [7:0]                   opd_addr;
    logic [`ACC_DATA_W-1:0]       opd_imm;
    logic [`ACC_DATA_W-1:0]       opd_mem_data;
    logic                         opd_illegal;

    // execute back to memory, and on to the queue
    logic                         st_en;
    logic [7:0]                   st_addr;
    logic [`ACC_DATA_W-1:0]       st_data;
    logic                         exe_valid;
    logic [`ACC_DATA_W-1:0]       exe_acc;
    logic                         exe_err;

    instr_buffer instr_buffer_i (
        .clk, .rst, .instr_valid, .instr, .slot_free,
        .instr_credit, .launch_valid, .launch_instr
    );

    decode_stage decode_stage_i (
        .clk, .rst, .launch_valid, .launch_instr,
        .dec_valid, .dec_kind, .dec_op, .dec_addr, .dec_imm, .dec_mem_read, .dec_illegal
    );

    operand_stage operand_stage_i (
        .clk, .rst,
        .dec_valid, .dec_kind, .dec_op, .dec_addr, .dec_imm, .dec_mem_read, .dec_illegal,
        .st_en, .st_addr, .st_data,
        .opd_valid, .opd_kind, .opd_op, .opd_addr, .opd_imm, .opd_mem_data, .opd_illegal
    );

    execute_stage execute_stage_i (
        .clk, .rst,
        .opd_valid, .opd_kind, .opd_op, .opd_addr, .opd_imm, .opd_mem_data, .opd_illegal,
        .st_en, .st_addr, .st_data, .exe_valid, .exe_acc, .exe_err
    );

    result_stage result_stage_i (
        .clk, .rst, .launch_valid, .exe_valid, .exe_acc, .exe_err, .res_credit,
        .slot_free, .res_valid, .res_data, .res_err
    );

endmodule

`default_nettype wire

//--- sim/acc_pipe_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "acc_pipe_config.svh"

module acc_pipe_checker (
    input wire clk,
    input wire rst,
    input wire instr_valid,
    input wire instr_credit,
    input wire launch_valid,
    input wire dec_valid,
    input wire opd_valid,
    input wire exe_valid,
    input wire res_valid,
    input wire res_credit
);

    // sink credits the result stage should still hold
    int sink_credits;
    // host side bookkeeping
    int ins_received;
    int credits_back;
    // failed assertions so far
    int fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            sink_credits <= `ACC_RES_CREDITS;
            ins_received <= 0;
            credits_back <= 0;
        end else begin
            sink_credits <= sink_credits + int'(res_credit) - int'(res_valid);
            ins_received <= ins_received + int'(instr_valid);
            credits_back <= credits_back + int'(instr_credit);
        end
    end

    // every result spends a credit that was there
    res_needs_credit: assert property (
        @(posedge clk) disable iff (rst) res_valid |-> sink_credits > 0
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("result emitted with no sink credit left");
    end

    // an entry must have arrived before its credit comes back
    credit_after_instr: assert property (
        @(posedge clk) disable iff (rst) instr_credit |-> credits_back < ins_received
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("instruction credit returned with no instruction held");
    end

    // registered valids are cleared by every reset cycle
    quiet_in_reset: assert property (
        @(posedge clk) rst |=> !(launch_valid || dec_valid || opd_valid
                                 || exe_valid || res_valid || instr_credit)
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("valid signal high during reset");
    end

endmodule

`default_nettype wire

//--- sim/acc_pipe_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "acc_pipe_config.svh"

module acc_pipe_tb;

    localparam int W = `ACC_DATA_W;
    // all tests together need well under 1000 cycles
    localparam int CYCLE_LIMIT = 4000;

    logic                 clk;
    logic                 rst = 1'b1;
    logic                 instr_valid = 1'b0;
    acc_pipe_pkg::instr_t instr = '0;
    logic                 res_credit = 1'b0;
    logic                 instr_credit;
    logic                 res_valid;
    logic [W-1:0]         res_data;
    logic                 res_err;

    // host credits, sink credits owed back, run bookkeeping
    int          host_credits = `ACC_INS_CREDITS;
    int          sink_owed = 0;
    logic        hold_sink = 1'b0;
    int          cyc = 0;
    int          res_cyc = 0;
    int          seed = 32'ha293;
    string       test_name = "none";
    logic [15:0] stim_q [$];
    logic [W-1:0] exp_data [$];
    logic        exp_err [$];
    logic [W-1:0] exp_d;
    logic        exp_e;

    // reference state
    logic [W-1:0] acc_m = '0;
    logic [W-1:0] mem_m [`ACC_DMEM_DEPTH];

    acc_pipe_top dut_i (
        .clk, .rst, .instr_valid, .instr, .res_credit,
        .instr_credit, .res_valid, .res_data, .res_err
    );

    bind acc_pipe_top acc_pipe_checker checker_i (
        .clk, .rst, .instr_valid, .instr_credit, .launch_valid, .dec_valid,
        .opd_valid, .exe_valid, .res_valid, .res_credit
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s in test %s", what, test_name);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // hang guard
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, pipeline stopped responding", cyc);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    // sink returns one owed credit per cycle unless holding back
    always @(posedge clk) begin
        #2;
        if (!hold_sink && sink_owed > 0) begin
            res_credit = 1'b1;
            sink_owed = sink_owed - 1;
        end else begin
            res_credit = 1'b0;
        end
    end

    // outputs sampled mid-cycle, well away from the edge
    always @(negedge clk) begin
        if (instr_credit) begin
            host_credits = host_credits + 1;
        end
        if (res_valid) begin
            sink_owed = sink_owed + 1;
            res_cyc = cyc;
            assert (exp_data.size() > 0)
                else report_failure("result arrived with none outstanding");
            exp_d = exp_data.pop_front();
            exp_e = exp_err.pop_front();
            assert (res_data == exp_d)
                else report_mismatch(test_name, 32'(exp_d), 32'(res_data));
            assert (res_err == exp_e)
                else report_mismatch(test_name, 32'(exp_e), 32'(res_err));
        end
    end

    // credit and reset protocol watched by the bound checker
    always @(negedge clk) begin
        assert (dut_i.checker_i.fail_cnt == 0)
            else report_failure("protocol assertion failed in the bound checker");
    end

    function automatic logic [15:0] imm_word(input logic [3:0] kind, input logic [11:0] imm);
        return {kind, imm};
    endfunction

    function automatic logic [15:0] mem_word(input logic [3:0] kind, input logic [3:0] op,
                                             input logic [7:0] addr);
        return {kind, op, addr};
    endfunction

    function automatic logic [15:0] rand_word();
        return 16'($random(seed));
    endfunction

    // ALU rules: acc is the left operand, b the memory word
    function automatic logic [W-1:0] alu_ref(input logic [3:0] op, input logic [W-1:0] a,
                                             input logic [W-1:0] b);
        logic [2*W-1:0] prod;
        prod = (2*W)'(a) * (2*W)'(b);
        case (op)
            acc_pipe_pkg::ALU_ADD:  return a + b;
            acc_pipe_pkg::ALU_SUB:  return a - b;
            acc_pipe_pkg::ALU_MUL:  return prod[W-1:0];
            acc_pipe_pkg::ALU_DIV:  return (b == '0) ? '1 : a / b;
            acc_pipe_pkg::ALU_SHL:  return {a[W-2:0], 1'b0};
            acc_pipe_pkg::ALU_SHR:  return {1'b0, a[W-1:1]};
            acc_pipe_pkg::ALU_ROL:  return {a[W-2:0], a[W-1]};
            acc_pipe_pkg::ALU_ROR:  return {a[0], a[W-1:1]};
            acc_pipe_pkg::ALU_AND:  return a & b;
            acc_pipe_pkg::ALU_OR:   return a | b;
            acc_pipe_pkg::ALU_XOR:  return a ^ b;
            acc_pipe_pkg::ALU_NOR:  return ~(a | b);
            acc_pipe_pkg::ALU_NAND: return ~(a & b);
            acc_pipe_pkg::ALU_XNOR: return ~(a ^ b);
            acc_pipe_pkg::ALU_GT:   return (a > b) ? W'(1) : W'(0);
            default:                return (a == b) ? W'(1) : W'(0);
        endcase
    endfunction

    // one instruction through the model, expected result queued
    task automatic model_step(input logic [15:0] word);
        logic err;
        err = 1'b0;
        case (word[15:12])
            acc_pipe_pkg::KIND_LDI:  acc_m = W'(word[11:0]);
            acc_pipe_pkg::KIND_ADDI: acc_m = acc_m + W'(word[11:0]);
            acc_pipe_pkg::KIND_LD:   acc_m = mem_m[word[7:0]];
            acc_pipe_pkg::KIND_ST:   mem_m[word[7:0]] = acc_m;
            acc_pipe_pkg::KIND_OPM:  acc_m = alu_ref(word[11:8], acc_m, mem_m[word[7:0]]);
            default:                 err = 1'b1;
        endcase
        exp_data.push_back(acc_m);
        exp_err.push_back(err);
    endtask

    // back to back while host credits last, gives up after budget cycles
    task automatic play_stream(input int budget);
        int used;
        logic [15:0] word;
        used = 0;
        while (stim_q.size() != 0 && used < budget) begin
            @(posedge clk);
            #2;
            used = used + 1;
            if (host_credits > 0) begin
                word = stim_q.pop_front();
                instr = word;
                instr_valid = 1'b1;
                host_credits = host_credits - 1;
                model_step(word);
            end else begin
                instr_valid = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
        assert (host_credits == `ACC_INS_CREDITS)
            else report_mismatch(test_name, `ACC_INS_CREDITS, 32'(host_credits));
    endtask

    // full 16-bit value built from the 12-bit immediate, then stored
    task automatic queue_value(input logic [15:0] value, input logic [7:0] addr);
        stim_q.push_back(imm_word(acc_pipe_pkg::KIND_LDI, value[15:4]));
        repeat (4) begin
            stim_q.push_back(mem_word(acc_pipe_pkg::KIND_OPM, acc_pipe_pkg::ALU_SHL, addr));
        end
        stim_q.push_back(imm_word(acc_pipe_pkg::KIND_ADDI, {8'h00, value[3:0]}));
        stim_q.push_back(mem_word(acc_pipe_pkg::KIND_ST, acc_pipe_pkg::ALU_ADD, addr));
    endtask

    task automatic test_reset_latency();
        int sent_cyc;
        logic [15:0] word;
        test_name = "reset_latency";
        repeat (8) begin
            @(negedge clk);
            assert (!res_valid && !instr_credit)
                else report_failure("output active on an idle pipe after reset");
        end
        @(posedge clk);
        #2;
        word = imm_word(acc_pipe_pkg::KIND_LDI, 12'habc);
        instr = word;
        instr_valid = 1'b1;
        host_credits = host_credits - 1;
        model_step(word);
        // sampled on the next edge
        sent_cyc = cyc + 1;
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
        wait_drain();
        assert (res_cyc - sent_cyc == 5)
            else report_mismatch(test_name, 32'd5, 32'(res_cyc - sent_cyc));
    endtask

    task automatic test_imm_chain();
        test_name = "imm_chain";
        repeat (12) begin
            stim_q.push_back(imm_word(acc_pipe_pkg::KIND_ADDI, 12'(rand_word() >> 4)));
        end
        // enough 0xfff steps to pass 16 bits
        stim_q.push_back(imm_word(acc_pipe_pkg::KIND_LDI, 12'hfff));
        repeat (20) begin
            stim_q.push_back(imm_word(acc_pipe_pkg::KIND_ADDI, 12'hfff));
        end
        play_stream(1000);
        wait_drain();
    endtask

    task automatic test_store_load();
        logic [15:0] v;
        test_name = "store_load";
        for (int i = 0; i < 4; i++) begin
            v = rand_word();
            queue_value(v, 8'h10 + 8'(i));
            // second store differs, load right behind it needs the bypass
            queue_value(~v, 8'h10 + 8'(i));
            stim_q.push_back(mem_word(acc_pipe_pkg::KIND_LD, acc_pipe_pkg::ALU_ADD,
                                      8'h10 + 8'(i)));
        end
        stim_q.push_back(imm_word(acc_pipe_pkg::KIND_LDI, 12'h000));
        for (int i = 3; i >= 0; i--) begin
            stim_q.push_back(mem_word(acc_pipe_pkg::KIND_LD, acc_pipe_pkg::ALU_ADD,
                                      8'h10 + 8'(i)));
        end
        play_stream(1000);
        wait_drain();
    endtask

    task automatic test_alu_ops();
        test_name = "alu_ops";
        for (int op = 0; op < 16; op++) begin
            queue_value(rand_word(), 8'h40 + 8'(op));
            queue_value(rand_word(), 8'h60 + 8'(op));
            stim_q.push_back(mem_word(acc_pipe_pkg::KIND_LD, 4'h0, 8'h40 + 8'(op)));
            stim_q.push_back(mem_word(acc_pipe_pkg::KIND_OPM, 4'(op), 8'h60 + 8'(op)));
        end
        // divide by zero, then compares of a word with itself
        stim_q.push_back(imm_word(acc_pipe_pkg::KIND_LDI, 12'h000));
        stim_q.push_back(mem_word(acc_pipe_pkg::KIND_ST, 4'h0, 8'h80));
        stim_q.push_back(mem_word(acc_pipe_pkg::KIND_LD, 4'h0, 8'h40));
        stim_q.push_back(mem_word(acc_pipe_pkg::KIND_OPM, acc_pipe_pkg::ALU_DIV, 8'h80));
        stim_q.push_back(mem_word(acc_pipe_pkg::KIND_LD, 4'h0, 8'h41));
        stim_q.push_back(mem_word(acc_pipe_pkg::KIND_OPM, acc_pipe_pkg::ALU_EQ, 8'h41));
        stim_q.push_back(mem_word(acc_pipe_pkg::KIND_LD, 4'h0, 8'h42));
        stim_q.push_back(mem_word(acc_pipe_pkg::KIND_OPM, acc_pipe_pkg::ALU_GT, 8'h42));
        play_stream(1000);
        wait_drain();
    endtask

    task automatic test_backpressure();
        test_name = "backpressure";
        @(negedge clk);
        hold_sink = 1'b1;
        for (int i = 0; i < 24; i++) begin
            stim_q.push_back(imm_word((i % 3 == 0) ? acc_pipe_pkg::KIND_LDI
                                                   : acc_pipe_pkg::KIND_ADDI, 12'(i * 37)));
        end
        // queue, buffer and sink credits together hold fewer than 24
        play_stream(60);
        assert (host_credits == 0)
            else report_failure("host credits did not run out under back-pressure");
        assert (stim_q.size() > 0)
            else report_failure("all instructions accepted with the sink stalled");
        repeat (20) begin
            @(negedge clk);
            assert (!instr_credit)
                else report_failure("instruction credit returned while the queue was full");
        end
        @(negedge clk);
        hold_sink = 1'b0;
        play_stream(1000);
        wait_drain();
    endtask

    task automatic test_illegal();
        test_name = "illegal";
        stim_q.push_back(imm_word(acc_pipe_pkg::KIND_LDI, 12'(rand_word() >> 4)));
        for (int k = 5; k < 16; k++) begin
            stim_q.push_back(imm_word(4'(k), 12'(rand_word())));
            stim_q.push_back(imm_word(acc_pipe_pkg::KIND_ADDI, 12'(k)));
        end
        // memory untouched by the illegal words
        stim_q.push_back(mem_word(acc_pipe_pkg::KIND_LD, 4'h0, 8'h60));
        stim_q.push_back(mem_word(acc_pipe_pkg::KIND_OPM, acc_pipe_pkg::ALU_XOR, 8'h61));
        play_stream(1000);
        wait_drain();
    endtask

    initial begin
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_latency();
        test_imm_chain();
        test_store_load();
        test_alu_ops();
        test_backpressure();
        test_illegal();
        repeat (4) @(negedge clk);
        if (dut_i.checker_i.fail_cnt == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_failure("protocol assertion failed in the bound checker");
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/acc_pipe_pkg.sv
source/instr_buffer.sv
source/decode_stage.sv
source/operand_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/acc_pipe_top.sv
sim/acc_pipe_checker.sv
sim/acc_pipe_tb.sv

//--- Makefile
# Verilator build and run for the accumulator pipeline testbench
VERILATOR ?= verilator
TOP       ?= acc_pipe_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a $fatal in the testbench makes the binary exit nonzero
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
